/* rtl/vec_params.svh */
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Vector register geometry, SEW fixed at 8 with LMUL 1
`define VLEN        64
`define SEW         8
`define NUM_ELEM    8
`define NUM_VREG    32
`define VREG_IDX_W  5

// Scalar side
`define XLEN        32

// Intake and command queue
`define ISSUE_LANE  2
`define CQ_DEPTH    4

// Major opcode of OP-V
`define OPCODE_OPV  7'b1010111

`endif

/* rtl/vec_pkg.sv */
`include "vec_params.svh"

package vec_pkg;

    typedef logic [`SEW-1:0]         elem_t;
    typedef elem_t [`NUM_ELEM-1:0]   vreg_t;
    typedef logic [`VREG_IDX_W-1:0]  vreg_idx_t;

    // Operand forms selected by funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } funct3_e;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, MV} alu_op_e;

    // Where operand 1 comes from
    typedef enum logic [1:0] {VREG, SCALAR, IMM} src_sel_e;

    // funct6 of the supported integer ops
    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;
    localparam logic [5:0] F6_VAND = 6'b001001;
    localparam logic [5:0] F6_VOR  = 6'b001010;
    localparam logic [5:0] F6_VXOR = 6'b001011;
    localparam logic [5:0] F6_VMV  = 6'b010111;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        vreg_idx_t  vs2;
        vreg_idx_t  vs1;
        logic [2:0] funct3;
        vreg_idx_t  vd;
        logic [6:0] opcode;
    } inst_vv_t;

    // Same layout, bits 19..15 carry the immediate
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        vreg_idx_t  vs2;
        logic [4:0] simm5;
        logic [2:0] funct3;
        vreg_idx_t  vd;
        logic [6:0] opcode;
    } inst_vi_t;

    typedef union packed {
        inst_vv_t vv;
        inst_vi_t vi;
    } inst_word_u;

endpackage

/* rtl/vec_if.sv */
`include "vec_params.svh"

interface cq_if
    import vec_pkg::*;
();
    logic             empty;
    inst_word_u       inst;
    logic [`XLEN-1:0] rs1_data;
    logic             pop;

    // inst and rs1_data are the oldest entry
    modport queue   (output empty, inst, rs1_data, input pop);
    modport decoder (input empty, inst, rs1_data, output pop);
endinterface

interface uop_if
    import vec_pkg::*;
();
    logic      valid;
    alu_op_e   op;
    src_sel_e  src_sel;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    logic      illegal;

    modport decoder (output valid, op, src_sel, vd, vs1, vs2, scalar, illegal);
    modport execute (input valid, op, src_sel, vd, vs1, vs2, scalar, illegal);
endinterface

interface vrf_rd_if
    import vec_pkg::*;
();
    vreg_idx_t vs1_idx;
    vreg_idx_t vs2_idx;
    vreg_t     vs1_data;
    vreg_t     vs2_data;

    modport reader (output vs1_idx, vs2_idx, input vs1_data, vs2_data);
    modport file   (input vs1_idx, vs2_idx, output vs1_data, vs2_data);
endinterface

interface wb_if
    import vec_pkg::*;
();
    logic      valid;
    vreg_idx_t vd;
    vreg_t     data;
    logic      illegal;

    modport source (output valid, vd, data, illegal);
    modport sink   (input valid, vd, data, illegal);
endinterface

/* rtl/cmd_queue.sv */
`include "vec_params.svh"

module cmd_queue
    import vec_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`ISSUE_LANE-1:0]             insts_valid,
    input  inst_word_u [`ISSUE_LANE-1:0]       inst_word,
    input  logic [`ISSUE_LANE-1:0][`XLEN-1:0]  rs1_data,
    output logic [`ISSUE_LANE-1:0]             insts_ready,
    cq_if.queue                                cq
);
    localparam int PTR_W = $clog2(`CQ_DEPTH);
    localparam int CNT_W = $clog2(`CQ_DEPTH + 1);

    inst_word_u             inst_mem [`CQ_DEPTH];
    logic [`XLEN-1:0]       rs1_mem  [`CQ_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic [CNT_W-1:0]       n_push;
    logic [`ISSUE_LANE-1:0] push;

    always_comb begin
        n_push = '0;
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            // Lane k needs k+1 free slots
            insts_ready[k] = (int'(count) + k + 1 <= `CQ_DEPTH);
            push[k] = insts_valid[k] && insts_ready[k];
            n_push = n_push + CNT_W'(push[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_push);
            rd_ptr <= rd_ptr + PTR_W'(cq.pop);
            count  <= count + n_push - CNT_W'(cq.pop);
        end
    end

    // Accepted lanes are contiguous from lane 0, so lane k lands at wr_ptr+k
    always_ff @(posedge clk) begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            if (push[k]) begin
                inst_mem[wr_ptr + PTR_W'(k)] <= inst_word[k];
                rs1_mem[wr_ptr + PTR_W'(k)]  <= rs1_data[k];
            end
        end
    end

    assign cq.empty    = (count == '0);
    assign cq.inst     = inst_mem[rd_ptr];
    assign cq.rs1_data = rs1_mem[rd_ptr];

    a_push_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        !(push[1] && !push[0]))
        else $error("cmd_queue: lane 1 accepted without lane 0");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        cq.pop |-> !cq.empty)
        else $error("cmd_queue: pop while empty");

endmodule

/* rtl/uop_decode.sv */
`include "vec_params.svh"

module uop_decode
    import vec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    cq_if.decoder   cq,
    uop_if.decoder  uop
);
    alu_op_e  op_d;
    src_sel_e src_d;
    elem_t    scalar_d;
    logic     illegal_d;

    // Nothing downstream stalls, so take one entry every cycle
    assign cq.pop = !cq.empty;

    always_comb begin
        op_d      = ADD;
        src_d     = VREG;
        scalar_d  = '0;
        illegal_d = 1'b0;

        case (cq.inst.vv.funct6)
            F6_VADD: op_d = ADD;
            F6_VSUB: op_d = SUB;
            F6_VAND: op_d = AND;
            F6_VOR:  op_d = OR;
            F6_VXOR: op_d = XOR;
            F6_VMV:  op_d = MV;
            default: illegal_d = 1'b1;
        endcase

        case (cq.inst.vv.funct3)
            OPIVV: src_d = VREG;
            OPIVX: begin
                src_d    = SCALAR;
                scalar_d = cq.rs1_data[`SEW-1:0];
            end
            OPIVI: begin
                // simm5 sign-extended to one element
                src_d    = IMM;
                scalar_d = {{(`SEW - 5){cq.inst.vi.simm5[4]}}, cq.inst.vi.simm5};
            end
            default: illegal_d = 1'b1;
        endcase

        if (cq.inst.vv.opcode != `OPCODE_OPV) begin
            illegal_d = 1'b1;
        end
        // vsub has no immediate form
        if (op_d == SUB && cq.inst.vv.funct3 == OPIVI) begin
            illegal_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uop.valid <= 1'b0;
        end else begin
            uop.valid <= cq.pop;
        end
    end

    always_ff @(posedge clk) begin
        if (cq.pop) begin
            uop.op      <= op_d;
            uop.src_sel <= src_d;
            uop.vd      <= cq.inst.vv.vd;
            uop.vs1     <= cq.inst.vv.vs1;
            uop.vs2     <= cq.inst.vv.vs2;
            uop.scalar  <= scalar_d;
            uop.illegal <= illegal_d;
        end
    end

endmodule

/* rtl/vec_execute.sv */
`include "vec_params.svh"

module vec_execute
    import vec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    uop_if.execute    uop,
    vrf_rd_if.reader  rd,
    wb_if.source      wb
);
    vreg_t     vs1_val;
    vreg_t     vs2_val;
    vreg_t     op1;
    vreg_t     alu_res;
    logic      fwd_vs1;
    logic      fwd_vs2;
    logic      res_valid;
    logic      res_illegal;
    vreg_idx_t res_vd;
    vreg_t     res_data;

    assign rd.vs1_idx = uop.vs1;
    assign rd.vs2_idx = uop.vs2;

    // Previous result is written only at the end of this cycle
    assign fwd_vs1 = res_valid && !res_illegal && (res_vd == uop.vs1) && (uop.src_sel == VREG);
    assign fwd_vs2 = res_valid && !res_illegal && (res_vd == uop.vs2);
    assign vs1_val = fwd_vs1 ? res_data : rd.vs1_data;
    assign vs2_val = fwd_vs2 ? res_data : rd.vs2_data;

    always_comb begin
        case (uop.src_sel)
            SCALAR, IMM: op1 = {`NUM_ELEM{uop.scalar}};
            default:     op1 = vs1_val;
        endcase
    end

    // Element-wise, wraps modulo 2^SEW
    always_comb begin
        for (int e = 0; e < `NUM_ELEM; e++) begin
            case (uop.op)
                ADD:     alu_res[e] = vs2_val[e] + op1[e];
                SUB:     alu_res[e] = vs2_val[e] - op1[e];
                AND:     alu_res[e] = vs2_val[e] & op1[e];
                OR:      alu_res[e] = vs2_val[e] | op1[e];
                XOR:     alu_res[e] = vs2_val[e] ^ op1[e];
                default: alu_res[e] = op1[e];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= uop.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop.valid) begin
            res_vd      <= uop.vd;
            res_data    <= alu_res;
            res_illegal <= uop.illegal;
        end
    end

    assign wb.valid   = res_valid;
    assign wb.vd      = res_vd;
    assign wb.data    = res_data;
    assign wb.illegal = res_illegal;

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        uop.valid |-> !$isunknown(uop.op))
        else $error("vec_execute: valid uop with unknown op");

endmodule

/* rtl/vec_retire.sv */
`include "vec_params.svh"

module vec_retire
    import vec_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    vrf_rd_if.file     rd,
    wb_if.sink         wb,
    output logic       rt_valid,
    output vreg_idx_t  rt_vd,
    output vreg_t      rt_data,
    output logic       rt_illegal
);
    vreg_t vrf [`NUM_VREG];

    // Two asynchronous read ports
    assign rd.vs1_data = vrf[rd.vs1_idx];
    assign rd.vs2_data = vrf[rd.vs2_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_VREG; i++) begin
                vrf[i] <= '0;
            end
        end else if (wb.valid && !wb.illegal) begin
            vrf[wb.vd] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rt_valid <= 1'b0;
        end else begin
            rt_valid <= wb.valid;
        end
    end

    // Illegal ops report zero data
    always_ff @(posedge clk) begin
        if (wb.valid) begin
            rt_vd      <= wb.vd;
            rt_data    <= wb.illegal ? '0 : wb.data;
            rt_illegal <= wb.illegal;
        end
    end

endmodule

/* rtl/vec_backend_top.sv */
`include "vec_params.svh"

module vec_backend_top
    import vec_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`ISSUE_LANE-1:0]             insts_valid,
    output logic [`ISSUE_LANE-1:0]             insts_ready,
    input  inst_word_u [`ISSUE_LANE-1:0]       inst_word,
    input  logic [`ISSUE_LANE-1:0][`XLEN-1:0]  rs1_data,
    output logic                               rt_valid,
    output vreg_idx_t                          rt_vd,
    output vreg_t                              rt_data,
    output logic                               rt_illegal
);
    cq_if     cq ();
    uop_if    uop ();
    vrf_rd_if vrf_rd ();
    wb_if     wb ();

    cmd_queue u_cmd_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .inst_word   (inst_word),
        .rs1_data    (rs1_data),
        .insts_ready (insts_ready),
        .cq          (cq)
    );

    uop_decode u_uop_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .cq    (cq),
        .uop   (uop)
    );

    vec_execute u_vec_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .uop   (uop),
        .rd    (vrf_rd),
        .wb    (wb)
    );

    vec_retire u_vec_retire (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd         (vrf_rd),
        .wb         (wb),
        .rt_valid   (rt_valid),
        .rt_vd      (rt_vd),
        .rt_data    (rt_data),
        .rt_illegal (rt_illegal)
    );

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for 10 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verif/tb_vec_backend.sv */
`include "vec_params.svh"

module tb_vec_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;
    localparam logic [5:0] LEGAL_F6 [6] = '{6'd0, 6'd2, 6'd9, 6'd10, 6'd11, 6'd23};
    localparam logic [2:0] FORMS [3] = '{3'd0, 3'd4, 3'd3};

    logic                              clk;
    logic                              rst_n;
    logic [`ISSUE_LANE-1:0]            insts_valid;
    logic [`ISSUE_LANE-1:0]            insts_ready;
    logic [`ISSUE_LANE-1:0][31:0]      inst_word;
    logic [`ISSUE_LANE-1:0][`XLEN-1:0] rs1_data;
    logic                              rt_valid;
    logic [`VREG_IDX_W-1:0]            rt_vd;
    logic [`VLEN-1:0]                  rt_data;
    logic                              rt_illegal;

    logic [`VLEN-1:0]       vrf_model [`NUM_VREG];
    logic [31:0]            pend_word[$];
    logic [31:0]            pend_rs1[$];
    logic [`VLEN-1:0]       exp_data[$];
    logic [`VREG_IDX_W-1:0] exp_vd[$];
    logic                   exp_ill[$];
    logic                   saw_full;
    integer                 seed = 32'h6e15;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    vec_backend_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts_ready (insts_ready),
        .inst_word   (inst_word),
        .rs1_data    (rs1_data),
        .rt_valid    (rt_valid),
        .rt_vd       (rt_vd),
        .rt_data     (rt_data),
        .rt_illegal  (rt_illegal)
    );

    // Unmasked OP-V word, vs1 doubles as simm5
    function automatic logic [31:0] encode_op(input logic [5:0] f6, input logic [2:0] f3,
                                              input logic [4:0] vd, input logic [4:0] vs1,
                                              input logic [4:0] vs2);
        return {f6, 1'b1, vs2, vs1, f3, vd, `OPCODE_OPV};
    endfunction

    // Executes one instruction on the model register file
    function automatic logic [`VLEN-1:0] model_exec(input logic [31:0] iw,
                                                    input logic [31:0] rs1, output logic ill);
        logic [5:0]       f6;
        logic [2:0]       f3;
        logic [`SEW-1:0]  sc;
        logic [`SEW-1:0]  a;
        logic [`SEW-1:0]  b;
        logic [`VLEN-1:0] res;
        f6 = iw[31:26];
        f3 = iw[14:12];
        ill = (iw[6:0] != `OPCODE_OPV) || !(f6 inside {6'd0, 6'd2, 6'd9, 6'd10, 6'd11, 6'd23})
            || !(f3 inside {3'd0, 3'd3, 3'd4}) || (f6 == 6'd2 && f3 == 3'd3);
        sc = (f3 == 3'd4) ? rs1[`SEW-1:0] : {{(`SEW - 5){iw[19]}}, iw[19:15]};
        res = '0;
        for (int e = 0; e < `NUM_ELEM; e++) begin
            b = vrf_model[iw[24:20]][e*`SEW +: `SEW];
            a = (f3 == 3'd0) ? vrf_model[iw[19:15]][e*`SEW +: `SEW] : sc;
            case (f6)
                6'd0:    res[e*`SEW +: `SEW] = b + a;
                6'd2:    res[e*`SEW +: `SEW] = b - a;
                6'd9:    res[e*`SEW +: `SEW] = b & a;
                6'd10:   res[e*`SEW +: `SEW] = b | a;
                6'd11:   res[e*`SEW +: `SEW] = b ^ a;
                default: res[e*`SEW +: `SEW] = a;
            endcase
        end
        if (ill) begin
            res = '0;
        end else begin
            vrf_model[iw[11:7]] = res;
        end
        return res;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0d ns: %s: got %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    task automatic queue_inst(input logic [31:0] iw, input logic [31:0] rs1);
        pend_word.push_back(iw);
        pend_rs1.push_back(rs1);
    endtask

    // Mode 0 one lane, mode 1 both lanes, mode 2 random lane pattern
    task automatic issue_all(input int mode);
        int               lanes;
        int               n;
        int               stall;
        logic             ill;
        logic [`VLEN-1:0] d;
        stall = 0;
        while (pend_word.size() > 0) begin
            @(negedge clk);
            case (mode)
                0:       lanes = 1;
                1:       lanes = 2;
                default: lanes = $unsigned($random(seed)) % 3;
            endcase
            if (lanes > pend_word.size()) begin
                lanes = pend_word.size();
            end
            insts_valid = '0;
            n = 0;
            for (int k = 0; k < lanes; k++) begin
                insts_valid[k] = 1'b1;
                inst_word[k] = pend_word[k];
                rs1_data[k] = pend_rs1[k];
                // Readies only move on the rising edge
                if (insts_ready[k] && n == k) begin
                    n = k + 1;
                end
            end
            if (insts_ready != 2'b11) begin
                saw_full = 1'b1;
            end
            stall = (n == 0) ? stall + 1 : 0;
            if (stall > TIMEOUT) begin
                abort_run("Timeout: lane ready never came back");
            end
            for (int k = 0; k < n; k++) begin
                d = model_exec(pend_word.pop_front(), pend_rs1.pop_front(), ill);
                exp_data.push_back(d);
                exp_ill.push_back(ill);
                exp_vd.push_back(inst_word[k][11:7]);
            end
        end
        @(negedge clk);
        insts_valid = '0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_data.size() > 0 && cnt <= TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
    endtask

    // rt_* change on the rising edge, sample in mid cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1 && rt_valid === 1'b1) begin
            if (exp_data.size() == 0) begin
                abort_run("Retire seen with no instruction outstanding");
            end else begin
                check_value("rt_illegal", 64'(rt_illegal), 64'(exp_ill.pop_front()));
                check_value("rt_vd", 64'(rt_vd), 64'(exp_vd.pop_front()));
                check_value("rt_data", rt_data, exp_data.pop_front());
            end
        end
    end

    initial begin
        int          wait_cnt;
        int          rnd;
        logic [5:0]  f6;
        logic [2:0]  f3;
        logic [31:0] w;
        insts_valid = '0;
        inst_word = '0;
        rs1_data = '0;
        saw_full = 1'b0;
        for (int i = 0; i < `NUM_VREG; i++) begin
            vrf_model[i] = '0;
        end
        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                abort_run("Timeout: reset was never released");
            end
        end
        @(negedge clk);
        check_value("rt_valid after reset", 64'(rt_valid), 64'd0);
        check_value("insts_ready after reset", 64'(insts_ready), 64'd3);

        // Fill registers with vmv.v.x and vmv.v.i
        for (int r = 1; r <= 8; r++) begin
            queue_inst(encode_op(6'd23, 3'd4, 5'(r), 5'd0, 5'd0), $random(seed));
        end
        for (int r = 9; r <= 12; r++) begin
            queue_inst(encode_op(6'd23, 3'd3, 5'(r), 5'(r * 7), 5'd0), 32'd0);
        end
        issue_all(0);

        // ALU chain on v13 back to back, then a vs1 forward into v14
        for (int o = 0; o < 5; o++) begin
            for (int f = 0; f < 3; f++) begin
                if (!(LEGAL_F6[o] == 6'd2 && FORMS[f] == 3'd3)) begin
                    queue_inst(encode_op(LEGAL_F6[o], FORMS[f], 5'd13, 5'(o * 5 + f + 1),
                                         5'd13), $random(seed));
                end
            end
        end
        queue_inst(encode_op(6'd0, 3'd0, 5'd14, 5'd13, 5'd14), 32'd0);
        issue_all(1);
        check_value("lane ready fell on a full queue", 64'(saw_full), 64'd1);

        // Illegal forms, then read the targets back
        queue_inst(encode_op(6'd0, 3'd0, 5'd1, 5'd2, 5'd3) ^ 32'h64, 32'd0);
        queue_inst(encode_op(6'd2, 3'd3, 5'd2, 5'd5, 5'd2), 32'd0);
        queue_inst(encode_op(6'd1, 3'd0, 5'd3, 5'd4, 5'd5), 32'd0);
        queue_inst(encode_op(6'd0, 3'd1, 5'd4, 5'd4, 5'd5), 32'd0);
        for (int r = 1; r <= 4; r++) begin
            queue_inst(encode_op(6'd23, 3'd0, 5'(r + 19), 5'(r), 5'd0), 32'd0);
        end
        issue_all(0);

        // Random mix, some of it illegal
        for (int i = 0; i < 200; i++) begin
            rnd = $unsigned($random(seed)) % 8;
            f6 = (rnd < 6) ? LEGAL_F6[rnd] : 6'($random(seed));
            rnd = $unsigned($random(seed)) % 4;
            f3 = (rnd < 3) ? FORMS[rnd] : 3'($random(seed));
            w = encode_op(f6, f3, 5'($random(seed)), 5'($random(seed)), 5'($random(seed)));
            if ($unsigned($random(seed)) % 16 == 0) begin
                w[6:0] = 7'($random(seed));
            end
            queue_inst(w, $random(seed));
        end
        issue_all(2);

        // Copy every register onto itself to expose the final file
        for (int r = 0; r < `NUM_VREG; r++) begin
            queue_inst(encode_op(6'd23, 3'd0, 5'(r), 5'(r), 5'd0), 32'd0);
        end
        issue_all(1);
        wait_drain();

        if (exp_data.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("Timeout: an expected retire never came");
        end
    end

endmodule

/* files.f */
+incdir+rtl
rtl/vec_pkg.sv
rtl/vec_if.sv
rtl/cmd_queue.sv
rtl/uop_decode.sv
rtl/vec_execute.sv
rtl/vec_retire.sv
rtl/vec_backend_top.sv
verif/tb_clock_gen.sv
verif/tb_vec_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vec_backend
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
